// File: Makefile
TOP = tb_riscv_csrfile

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f sim.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -Mdir obj_dir -f sim.f
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "Regression passed"

clean:
	rm -rf obj_dir

// File: rtl/csr_machine_regs.sv
`default_nettype none
`timescale 1ns/10ps
`include "csr_params.svh"

module csr_machine_regs
  (
    input  logic                    i_riscv_csr_clk,
    input  logic                    i_riscv_csr_rst,
    input  csr_pkg::csr_addr_t      i_csr_address,
    input  logic                    i_write_en,
    input  logic [`CSR_XLEN-1:0]    i_write_data,
    input  logic                    i_mret,
    input  logic                    i_trap,
    input  csr_pkg::exc_cause_t     i_trap_cause,
    input  logic                    i_trap_is_int,
    input  logic                    i_ack_ext,
    input  csr_pkg::priv_lvl_t      i_priv_lvl,
    input  logic [`CSR_XLEN-1:0]    i_pc,
    input  logic [`CSR_XLEN-1:0]    i_fault_addr,
    input  logic [31:0]             i_inst,
    input  logic                    i_timer_int,
    input  logic                    i_external_int,
    output logic [`CSR_XLEN-1:0]    o_rdata,
    output logic                    o_unknown_addr,
    output logic [`CSR_XLEN-1:0]    o_mepc,
    output logic                    o_mstatus_mie,
    output csr_pkg::priv_lvl_t      o_mstatus_mpp,
    output logic                    o_mstatus_tsr,
    output logic                    o_mie_mtie,
    output logic                    o_mie_meie,
    output logic                    o_mip_mtip,
    output logic                    o_mip_meip,
    output logic [`CSR_XLEN-1:0]    o_mtvec
  );

  localparam int unsigned XLEN  = `CSR_XLEN;
  localparam int unsigned ALIGN = `CSR_VEC_ALIGN_BITS;

  logic                 mstatus_mpie;
  logic [XLEN-1:0]      mscratch;
  logic [XLEN-1:0]      mtval;
  logic                 mcause_int;
  csr_pkg::exc_cause_t  mcause_code;
  logic                 wr_ok;

  // An instruction that traps does not commit its CSR write
  assign wr_ok = i_write_en && !i_trap;

  always_ff @(posedge i_riscv_csr_clk or posedge i_riscv_csr_rst)
  begin
    if (i_riscv_csr_rst)
    begin
      o_mstatus_mie <= 1'b0;
      mstatus_mpie  <= 1'b0;
      o_mstatus_mpp <= csr_pkg::PRIV_LVL_U;
      o_mstatus_tsr <= 1'b0;
    end
    else if (i_trap)
    begin
      mstatus_mpie  <= o_mstatus_mie;   // Stack interrupt enable
      o_mstatus_mie <= 1'b0;
      o_mstatus_mpp <= i_priv_lvl;
    end
    else if (i_mret)
    begin
      o_mstatus_mie <= mstatus_mpie;
      mstatus_mpie  <= 1'b1;
      o_mstatus_mpp <= csr_pkg::PRIV_LVL_U;
    end
    else if (wr_ok && i_csr_address == csr_pkg::CSR_MSTATUS)
    begin
      o_mstatus_mie <= i_write_data[csr_pkg::MIE_BIT];
      mstatus_mpie  <= i_write_data[csr_pkg::MPIE_BIT];
      o_mstatus_tsr <= i_write_data[csr_pkg::TSR_BIT];
      // Only U and M exist, other encodings fall back to U
      o_mstatus_mpp <= (i_write_data[csr_pkg::MPP_LSB +: 2] == 2'b11) ?
                       csr_pkg::PRIV_LVL_M : csr_pkg::PRIV_LVL_U;
    end
  end

  always_ff @(posedge i_riscv_csr_clk or posedge i_riscv_csr_rst)
  begin
    if (i_riscv_csr_rst)
    begin
      o_mie_mtie <= 1'b0;
      o_mie_meie <= 1'b0;
      o_mip_mtip <= 1'b0;
      o_mip_meip <= 1'b0;
    end
    else
    begin
      if (wr_ok && i_csr_address == csr_pkg::CSR_MIE)
      begin
        o_mie_mtie <= i_write_data[csr_pkg::MTI_BIT];
        o_mie_meie <= i_write_data[csr_pkg::MEI_BIT];
      end
      o_mip_mtip <= i_timer_int;                          // Follows the timer level
      o_mip_meip <= i_ack_ext ? 1'b0 : i_external_int;    // Dropped when taken
    end
  end

  always_ff @(posedge i_riscv_csr_clk or posedge i_riscv_csr_rst)
  begin
    if (i_riscv_csr_rst)
      o_mtvec <= `CSR_MTVEC_RESET;
    else if (wr_ok && i_csr_address == csr_pkg::CSR_MTVEC)
    begin
      if (i_write_data[0])
        o_mtvec <= {i_write_data[XLEN-1:ALIGN], {(ALIGN-1){1'b0}}, 1'b1};   // Vectored
      else
        o_mtvec <= {i_write_data[XLEN-1:2], 2'b00};
    end
  end

  always_ff @(posedge i_riscv_csr_clk or posedge i_riscv_csr_rst)
  begin
    if (i_riscv_csr_rst)
    begin
      o_mepc      <= '0;
      mcause_int  <= 1'b0;
      mcause_code <= '0;
      mtval       <= '0;
    end
    else if (i_trap)
    begin
      o_mepc      <= {i_pc[XLEN-1:1], 1'b0};
      mcause_int  <= i_trap_is_int;
      mcause_code <= i_trap_cause;
      if (!i_trap_is_int && (i_trap_cause == csr_pkg::CAUSE_LOAD_MISALIGNED ||
                             i_trap_cause == csr_pkg::CAUSE_STORE_MISALIGNED))
        mtval <= i_fault_addr;
      else if (!i_trap_is_int && i_trap_cause == csr_pkg::CAUSE_ILLEGAL_INST)
        mtval <= {{(XLEN-32){1'b0}}, i_inst};   // Faulting instruction bits
      else
        mtval <= '0;
    end
    else if (wr_ok)
    begin
      case (i_csr_address)
        csr_pkg::CSR_MEPC   : o_mepc <= {i_write_data[XLEN-1:1], 1'b0};
        csr_pkg::CSR_MTVAL  : mtval  <= i_write_data;
        csr_pkg::CSR_MCAUSE :
        begin
          mcause_int  <= i_write_data[XLEN-1];
          mcause_code <= i_write_data[3:0];
        end
        default : ;
      endcase
    end
  end

  always_ff @(posedge i_riscv_csr_clk or posedge i_riscv_csr_rst)
  begin
    if (i_riscv_csr_rst)
      mscratch <= '0;
    else if (wr_ok && i_csr_address == csr_pkg::CSR_MSCRATCH)
      mscratch <= i_write_data;
  end

  // Read data depends on the address alone
  always_comb
  begin
    o_rdata        = '0;
    o_unknown_addr = 1'b0;
    case (i_csr_address)
      csr_pkg::CSR_MVENDORID,
      csr_pkg::CSR_MARCHID,
      csr_pkg::CSR_MIMPID,
      csr_pkg::CSR_MHARTID  : o_rdata = '0;   // Hardwired identity
      csr_pkg::CSR_MISA     : o_rdata = `CSR_MISA_VALUE;
      csr_pkg::CSR_MSTATUS  :
      begin
        o_rdata[csr_pkg::MIE_BIT]      = o_mstatus_mie;
        o_rdata[csr_pkg::MPIE_BIT]     = mstatus_mpie;
        o_rdata[csr_pkg::MPP_LSB +: 2] = o_mstatus_mpp;
        o_rdata[csr_pkg::TSR_BIT]      = o_mstatus_tsr;
      end
      csr_pkg::CSR_MIE      :
      begin
        o_rdata[csr_pkg::MTI_BIT] = o_mie_mtie;
        o_rdata[csr_pkg::MEI_BIT] = o_mie_meie;
      end
      csr_pkg::CSR_MIP      :
      begin
        o_rdata[csr_pkg::MTI_BIT] = o_mip_mtip;
        o_rdata[csr_pkg::MEI_BIT] = o_mip_meip;
      end
      csr_pkg::CSR_MTVEC    : o_rdata = o_mtvec;
      csr_pkg::CSR_MSCRATCH : o_rdata = mscratch;
      csr_pkg::CSR_MEPC     : o_rdata = o_mepc;
      csr_pkg::CSR_MCAUSE   : o_rdata = {mcause_int, {(XLEN-5){1'b0}}, mcause_code};
      csr_pkg::CSR_MTVAL    : o_rdata = mtval;
      default               : o_unknown_addr = 1'b1;
    endcase
  end

  // mret returns through mepc, an odd target would be unreachable
  a_mepc_aligned : assert property (@(posedge i_riscv_csr_clk)
    disable iff (i_riscv_csr_rst) !o_mepc[0])
    else $error("csr_machine_regs: mepc bit 0 set");

endmodule

`default_nettype wire

// File: rtl/csr_op_decode.sv
`default_nettype none
`timescale 1ns/10ps
`include "csr_params.svh"

module csr_op_decode
  (
    input  csr_pkg::csr_op_t      i_csr_op,
    input  csr_pkg::csr_addr_t    i_csr_address,
    input  logic [`CSR_XLEN-1:0]  i_csr_wdata,
    input  logic [`CSR_XLEN-1:0]  i_rdata,
    input  logic                  i_unknown_addr,
    input  csr_pkg::priv_lvl_t    i_priv_lvl,
    input  logic                  i_stall,
    output logic                  o_write_en,
    output logic [`CSR_XLEN-1:0]  o_write_data,
    output logic                  o_mret,
    output logic                  o_illegal_access
  );

  logic csr_access;
  logic wants_write;
  logic priv_fail;
  logic read_only_write;

  always_comb
  begin
    o_write_data = i_csr_wdata;
    csr_access   = 1'b1;
    wants_write  = 1'b1;
    case (i_csr_op)
      csr_pkg::CSR_WRITE : o_write_data = i_csr_wdata;
      csr_pkg::CSR_SET   : o_write_data = i_rdata | i_csr_wdata;    // Set bits
      csr_pkg::CSR_CLEAR : o_write_data = i_rdata & ~i_csr_wdata;   // Clear bits
      csr_pkg::CSR_READ  : wants_write  = 1'b0;
      default :
      begin
        // No op and mret touch no CSR
        csr_access  = 1'b0;
        wants_write = 1'b0;
      end
    endcase
  end

  // Address bits 9:8 hold the lowest privilege allowed to access
  assign priv_fail        = i_csr_address[9:8] > i_priv_lvl;
  assign read_only_write  = (i_csr_address[11:10] == 2'b11) && wants_write;
  assign o_illegal_access = csr_access && (priv_fail || i_unknown_addr || read_only_write);

  assign o_write_en = wants_write && !o_illegal_access && !i_stall;
  assign o_mret     = (i_csr_op == csr_pkg::CSR_MRET) && !i_stall;   // Held mret acts once

  always_comb
  begin
    assert (!(o_write_en && o_illegal_access))
      else $error("csr_op_decode: write enabled on an illegal access");
  end

endmodule

`default_nettype wire

// File: rtl/csr_params.svh
`ifndef CSR_PARAMS_SVH
`define CSR_PARAMS_SVH

// Register width of the hart
`define CSR_XLEN 64

// MXL = 64 bit, extensions I, M and U
`define CSR_MISA_VALUE 64'h8000_0000_0010_1100

// Trap base taken until software programs mtvec
`define CSR_MTVEC_RESET 64'h0000_0000_0000_0048

// Low mtvec bits forced to zero in vectored mode
`define CSR_VEC_ALIGN_BITS 8

`endif

// File: rtl/csr_pkg.sv
`default_nettype none

package csr_pkg;

  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'b00,
    PRIV_LVL_M = 2'b11
  } priv_lvl_t;

  typedef enum logic [2:0] {
    CSR_NONE  = 3'd0,
    CSR_WRITE = 3'd1,
    CSR_SET   = 3'd2,
    CSR_CLEAR = 3'd3,
    CSR_READ  = 3'd4,
    CSR_MRET  = 3'd5
  } csr_op_t;

  typedef enum logic [11:0] {
    CSR_MSTATUS   = 12'h300,
    CSR_MISA      = 12'h301,
    CSR_MIE       = 12'h304,
    CSR_MTVEC     = 12'h305,
    CSR_MSCRATCH  = 12'h340,
    CSR_MEPC      = 12'h341,
    CSR_MCAUSE    = 12'h342,
    CSR_MTVAL     = 12'h343,
    CSR_MIP       = 12'h344,
    CSR_MVENDORID = 12'hF11,
    CSR_MARCHID   = 12'hF12,
    CSR_MIMPID    = 12'hF13,
    CSR_MHARTID   = 12'hF14
  } csr_addr_t;

  // Exception and interrupt codes share the encoding space, mcause bit 63 tells them apart
  typedef logic [3:0] exc_cause_t;

  localparam exc_cause_t CAUSE_INST_MISALIGNED  = 4'd0;
  localparam exc_cause_t CAUSE_ILLEGAL_INST     = 4'd2;
  localparam exc_cause_t CAUSE_LOAD_MISALIGNED  = 4'd4;
  localparam exc_cause_t CAUSE_STORE_MISALIGNED = 4'd6;
  localparam exc_cause_t CAUSE_ECALL_U          = 4'd8;
  localparam exc_cause_t CAUSE_ECALL_M          = 4'd11;
  localparam exc_cause_t CAUSE_M_TIMER          = 4'd7;
  localparam exc_cause_t CAUSE_M_EXT            = 4'd11;

  localparam int unsigned MIE_BIT  = 3;   // mstatus
  localparam int unsigned MPIE_BIT = 7;
  localparam int unsigned MPP_LSB  = 11;
  localparam int unsigned TSR_BIT  = 22;
  localparam int unsigned MTI_BIT  = 7;   // mie and mip
  localparam int unsigned MEI_BIT  = 11;

endpackage

`default_nettype wire

// File: rtl/csr_trap_ctrl.sv
`default_nettype none
`timescale 1ns/10ps
`include "csr_params.svh"

module csr_trap_ctrl
  (
    input  logic                    i_riscv_csr_clk,
    input  logic                    i_riscv_csr_rst,
    input  logic                    i_illegal_access,
    input  logic                    i_illegal_inst,
    input  logic                    i_ecall,
    input  logic                    i_inst_addr_misaligned,
    input  logic                    i_load_addr_misaligned,
    input  logic                    i_store_addr_misaligned,
    input  logic                    i_flush,
    input  logic                    i_stall,
    input  logic                    i_mret,
    input  logic                    i_mstatus_mie,
    input  csr_pkg::priv_lvl_t      i_mstatus_mpp,
    input  logic                    i_mie_mtie,
    input  logic                    i_mie_meie,
    input  logic                    i_mip_mtip,
    input  logic                    i_mip_meip,
    input  logic [`CSR_XLEN-1:0]    i_mtvec,
    output logic                    o_trap,
    output csr_pkg::exc_cause_t     o_trap_cause,
    output logic                    o_trap_is_int,
    output logic                    o_ack_ext,
    output logic [`CSR_XLEN-1:0]    o_trap_address,
    output csr_pkg::priv_lvl_t      o_priv_lvl,
    output logic [1:0]              o_return_from_trap
  );

  logic                 int_enable;
  logic                 mei_go;
  logic                 mti_go;
  logic                 illegal;
  logic                 is_exception;
  logic [`CSR_XLEN-1:0] trap_base;

  // Machine interrupts are always live below machine mode
  assign int_enable = (o_priv_lvl == csr_pkg::PRIV_LVL_U) || i_mstatus_mie;
  assign mei_go     = i_mip_meip && i_mie_meie && int_enable;
  assign mti_go     = i_mip_mtip && i_mie_mtie && int_enable;

  assign illegal      = i_illegal_access || i_illegal_inst;
  assign is_exception = illegal || i_inst_addr_misaligned || i_ecall ||
                        i_load_addr_misaligned || i_store_addr_misaligned;

  // Fixed priority, interrupts first
  always_comb
  begin
    o_trap_is_int = 1'b0;
    o_trap_cause  = csr_pkg::CAUSE_INST_MISALIGNED;
    if (mei_go)
    begin
      o_trap_is_int = 1'b1;
      o_trap_cause  = csr_pkg::CAUSE_M_EXT;
    end
    else if (mti_go)
    begin
      o_trap_is_int = 1'b1;
      o_trap_cause  = csr_pkg::CAUSE_M_TIMER;
    end
    else if (illegal)
      o_trap_cause = csr_pkg::CAUSE_ILLEGAL_INST;
    else if (i_inst_addr_misaligned)
      o_trap_cause = csr_pkg::CAUSE_INST_MISALIGNED;
    else if (i_ecall)
      o_trap_cause = (o_priv_lvl == csr_pkg::PRIV_LVL_M) ?
                     csr_pkg::CAUSE_ECALL_M : csr_pkg::CAUSE_ECALL_U;
    else if (i_load_addr_misaligned)
      o_trap_cause = csr_pkg::CAUSE_LOAD_MISALIGNED;
    else if (i_store_addr_misaligned)
      o_trap_cause = csr_pkg::CAUSE_STORE_MISALIGNED;
  end

  assign o_trap    = (mei_go || mti_go || is_exception) && !i_flush && !i_stall;
  assign o_ack_ext = o_trap && mei_go;   // Lets mip drop the external bit

  assign trap_base = {i_mtvec[`CSR_XLEN-1:2], 2'b00};

  always_comb
  begin
    if (i_mtvec[0] && o_trap_is_int)
      o_trap_address = trap_base + {{(`CSR_XLEN-6){1'b0}}, o_trap_cause, 2'b00};   // 4 x cause
    else
      o_trap_address = trap_base;
  end

  assign o_return_from_trap = i_mret ? 2'd1 : 2'd0;

  always_ff @(posedge i_riscv_csr_clk or posedge i_riscv_csr_rst)
  begin
    if (i_riscv_csr_rst)
      o_priv_lvl <= csr_pkg::PRIV_LVL_M;
    else if (o_trap)
      o_priv_lvl <= csr_pkg::PRIV_LVL_M;
    else if (i_mret)
      o_priv_lvl <= i_mstatus_mpp;   // Back to the stacked level
  end

  // Stall freezes the pipeline, so no trap may redirect it
  a_no_trap_in_stall : assert property (@(posedge i_riscv_csr_clk)
    disable iff (i_riscv_csr_rst) i_stall |-> !o_trap)
    else $error("csr_trap_ctrl: trap taken during stall");

endmodule

`default_nettype wire

// File: rtl/riscv_csrfile.sv
`default_nettype none
`timescale 1ns/10ps
`include "csr_params.svh"

module riscv_csrfile
  (
    input  logic                    i_riscv_csr_clk,
    input  logic                    i_riscv_csr_rst,
    input  csr_pkg::csr_addr_t      i_csr_address,
    input  csr_pkg::csr_op_t        i_csr_op,
    input  logic [`CSR_XLEN-1:0]    i_csr_wdata,
    input  logic                    i_external_int,
    input  logic                    i_timer_int,
    input  logic [`CSR_XLEN-1:0]    i_pc,
    input  logic [`CSR_XLEN-1:0]    i_fault_addr,
    input  logic [31:0]             i_inst,
    input  logic                    i_illegal_inst,
    input  logic                    i_ecall,
    input  logic                    i_inst_addr_misaligned,
    input  logic                    i_load_addr_misaligned,
    input  logic                    i_store_addr_misaligned,
    input  logic                    i_flush,
    input  logic                    i_stall,
    output logic [`CSR_XLEN-1:0]    o_rdata,
    output logic [`CSR_XLEN-1:0]    o_return_address,
    output logic [`CSR_XLEN-1:0]    o_trap_address,
    output logic                    o_go_to_trap,
    output logic [1:0]              o_return_from_trap,
    output csr_pkg::priv_lvl_t      o_priv_lvl,
    output logic                    o_tsr
  );

  logic                 write_en;
  logic [`CSR_XLEN-1:0] write_data;
  logic                 mret;
  logic                 illegal_access;
  logic                 unknown_addr;
  csr_pkg::exc_cause_t  trap_cause;
  logic                 trap_is_int;
  logic                 ack_ext;
  logic                 mstatus_mie;
  csr_pkg::priv_lvl_t   mstatus_mpp;
  logic                 mie_mtie;
  logic                 mie_meie;
  logic                 mip_mtip;
  logic                 mip_meip;
  logic [`CSR_XLEN-1:0] mtvec;

  csr_op_decode u_op_decode
  (
    .i_csr_op         (i_csr_op),
    .i_csr_address    (i_csr_address),
    .i_csr_wdata      (i_csr_wdata),
    .i_rdata          (o_rdata),
    .i_unknown_addr   (unknown_addr),
    .i_priv_lvl       (o_priv_lvl),
    .i_stall          (i_stall),
    .o_write_en       (write_en),
    .o_write_data     (write_data),
    .o_mret           (mret),
    .o_illegal_access (illegal_access)
  );

  csr_machine_regs u_machine_regs
  (
    .i_riscv_csr_clk  (i_riscv_csr_clk),
    .i_riscv_csr_rst  (i_riscv_csr_rst),
    .i_csr_address    (i_csr_address),
    .i_write_en       (write_en),
    .i_write_data     (write_data),
    .i_mret           (mret),
    .i_trap           (o_go_to_trap),
    .i_trap_cause     (trap_cause),
    .i_trap_is_int    (trap_is_int),
    .i_ack_ext        (ack_ext),
    .i_priv_lvl       (o_priv_lvl),
    .i_pc             (i_pc),
    .i_fault_addr     (i_fault_addr),
    .i_inst           (i_inst),
    .i_timer_int      (i_timer_int),
    .i_external_int   (i_external_int),
    .o_rdata          (o_rdata),
    .o_unknown_addr   (unknown_addr),
    .o_mepc           (o_return_address),
    .o_mstatus_mie    (mstatus_mie),
    .o_mstatus_mpp    (mstatus_mpp),
    .o_mstatus_tsr    (o_tsr),
    .o_mie_mtie       (mie_mtie),
    .o_mie_meie       (mie_meie),
    .o_mip_mtip       (mip_mtip),
    .o_mip_meip       (mip_meip),
    .o_mtvec          (mtvec)
  );

  csr_trap_ctrl u_trap_ctrl
  (
    .i_riscv_csr_clk          (i_riscv_csr_clk),
    .i_riscv_csr_rst          (i_riscv_csr_rst),
    .i_illegal_access         (illegal_access),
    .i_illegal_inst           (i_illegal_inst),
    .i_ecall                  (i_ecall),
    .i_inst_addr_misaligned   (i_inst_addr_misaligned),
    .i_load_addr_misaligned   (i_load_addr_misaligned),
    .i_store_addr_misaligned  (i_store_addr_misaligned),
    .i_flush                  (i_flush),
    .i_stall                  (i_stall),
    .i_mret                   (mret),
    .i_mstatus_mie            (mstatus_mie),
    .i_mstatus_mpp            (mstatus_mpp),
    .i_mie_mtie               (mie_mtie),
    .i_mie_meie               (mie_meie),
    .i_mip_mtip               (mip_mtip),
    .i_mip_meip               (mip_meip),
    .i_mtvec                  (mtvec),
    .o_trap                   (o_go_to_trap),
    .o_trap_cause             (trap_cause),
    .o_trap_is_int            (trap_is_int),
    .o_ack_ext                (ack_ext),
    .o_trap_address           (o_trap_address),
    .o_priv_lvl               (o_priv_lvl),
    .o_return_from_trap       (o_return_from_trap)
  );

endmodule

`default_nettype wire

// File: sim.f
+incdir+rtl
rtl/csr_pkg.sv
rtl/csr_op_decode.sv
rtl/csr_machine_regs.sv
rtl/csr_trap_ctrl.sv
rtl/riscv_csrfile.sv
test/csr_checker.sv
test/tb_riscv_csrfile.sv

// File: test/csr_checker.sv
`default_nettype none
`timescale 1ns/10ps
`include "csr_params.svh"

module csr_checker
  (
    input  logic                  i_riscv_csr_clk,
    input  logic                  i_riscv_csr_rst,
    input  logic                  i_valid,
    input  logic [7:0]            i_mask,
    input  logic [11:0]           i_csr_address,
    input  logic [`CSR_XLEN-1:0]  i_rdata,
    input  logic [`CSR_XLEN-1:0]  i_return_address,
    input  logic [`CSR_XLEN-1:0]  i_trap_address,
    input  logic                  i_go_to_trap,
    input  logic [1:0]            i_return_from_trap,
    input  logic [1:0]            i_priv_lvl,
    input  logic                  i_tsr,
    input  logic [`CSR_XLEN-1:0]  i_exp_rdata,
    input  logic [`CSR_XLEN-1:0]  i_exp_return_address,
    input  logic [`CSR_XLEN-1:0]  i_exp_trap_address,
    input  logic                  i_exp_go_to_trap,
    input  logic [1:0]            i_exp_return_from_trap,
    input  logic [1:0]            i_exp_priv_lvl,
    output int                    o_check_count,
    output int                    o_error_count
  );

  int check_count = 0;
  int error_count = 0;

  task automatic check_value(input string name, input logic [`CSR_XLEN-1:0] actual,
                             input logic [`CSR_XLEN-1:0] expected);
    begin
      check_count = check_count + 1;
      if (actual !== expected)
      begin
        error_count = error_count + 1;
        $display("mismatch %s: got 0x%h, expected 0x%h at %0t ns", name, actual, expected,
                 $time);
      end
    end
  endtask

  // Outputs settled half a cycle after the drive edge
  always @(negedge i_riscv_csr_clk)
  begin
    if (!i_riscv_csr_rst && i_valid)
    begin
      if (i_mask[0])
        check_value("o_rdata", i_rdata, i_exp_rdata);
      if (i_mask[0] && i_csr_address == csr_pkg::CSR_MSTATUS)   // TSR as read back in mstatus
        check_value("o_tsr", {63'd0, i_tsr}, {63'd0, i_exp_rdata[csr_pkg::TSR_BIT]});
      if (i_mask[1])
        check_value("o_go_to_trap", {63'd0, i_go_to_trap}, {63'd0, i_exp_go_to_trap});
      if (i_mask[2])
        check_value("o_trap_address", i_trap_address, i_exp_trap_address);
      if (i_mask[3])
        check_value("o_return_address", i_return_address, i_exp_return_address);
      if (i_mask[4])
        check_value("o_return_from_trap", {62'd0, i_return_from_trap},
                    {62'd0, i_exp_return_from_trap});
      if (i_mask[5])
        check_value("o_priv_lvl", {62'd0, i_priv_lvl}, {62'd0, i_exp_priv_lvl});
    end
  end

  assign o_check_count = check_count;
  assign o_error_count = error_count;

endmodule

`default_nettype wire

// File: test/csr_vectors_input.txt
# op addr wdata flags pc fault inst mask exp_rdata exp_trap exp_taddr exp_raddr exp_rft exp_priv
# flags 0 ill 1 ecall 2 imis 3 lmis 4 smis 5 flush 6 stall 7 timer 8 ext
# mask 0 rdata 1 trap 2 taddr 3 raddr 4 rft 5 priv
4 301 0 0 0 0 0 23 8000000000101100 0 0 0 0 3
4 305 0 0 0 0 0 33 48 0 0 0 0 3
1 340 f0f0a5a5 0 0 0 0 03 0 0 0 0 0 0
2 340 f00 0 0 0 0 03 f0f0a5a5 0 0 0 0 0
3 340 f000a0 0 0 0 0 03 f0f0afa5 0 0 0 0 0
1 340 1234 40 0 0 0 03 f000af05 0 0 0 0 0
4 340 0 0 0 0 0 03 f000af05 0 0 0 0 0
0 340 0 2 1000 0 0 26 0 1 48 0 0 3
4 342 0 0 0 0 0 0b b 0 0 1000 0 0
1 300 80 0 0 0 0 03 1800 0 0 0 0 0
5 300 0 0 0 0 0 33 80 0 0 0 1 3
4 340 0 0 2004 0 34002573 36 0 1 48 0 0 0
4 342 0 0 0 0 0 2b 2 0 0 2004 0 3
4 343 0 0 0 0 0 03 34002573 0 0 0 0 0
1 305 3c5 0 0 0 0 03 48 0 0 0 0 0
1 304 80 0 0 0 0 03 0 0 0 0 0 0
1 300 8 0 0 0 0 03 80 0 0 0 0 0
4 305 0 80 0 0 0 03 301 0 0 0 0 0
4 344 0 80 3000 0 0 07 80 1 31c 0 0 0
4 342 0 0 0 0 0 0b 8000000000000007 0 0 3000 0 0
0 340 0 8 4000 4003 0 06 0 1 300 0 0 0
4 343 0 0 0 0 0 03 4003 0 0 0 0 0
0 340 0 2a 5000 5001 0 02 0 0 0 0 0 0
4 342 0 0 0 0 0 0b 4 0 0 4000 0 0
1 341 5001 0 0 0 0 03 4000 0 0 0 0 0
4 341 0 0 0 0 0 0b 5000 0 0 5000 0 0
4 7c0 0 0 6000 0 0 06 0 1 300 0 0 0
4 342 0 0 0 0 0 0b 2 0 0 6000 0 0

// File: test/tb_riscv_csrfile.sv
`default_nettype none
`timescale 1ns/10ps
`include "csr_params.svh"

module tb_riscv_csrfile;

  localparam int MAX_LINES     = 200;
  localparam int RESET_TIMEOUT = 10;

  logic                  clk;
  logic                  rst;
  csr_pkg::csr_addr_t    csr_address;
  csr_pkg::csr_op_t      csr_op;
  logic [`CSR_XLEN-1:0]  csr_wdata;
  logic                  external_int;
  logic                  timer_int;
  logic [`CSR_XLEN-1:0]  pc;
  logic [`CSR_XLEN-1:0]  fault_addr;
  logic [31:0]           inst;
  logic                  illegal_inst;
  logic                  ecall;
  logic                  inst_mis;
  logic                  load_mis;
  logic                  store_mis;
  logic                  flush;
  logic                  stall;
  logic [`CSR_XLEN-1:0]  rdata;
  logic [`CSR_XLEN-1:0]  return_address;
  logic [`CSR_XLEN-1:0]  trap_address;
  logic                  go_to_trap;
  logic [1:0]            return_from_trap;
  csr_pkg::priv_lvl_t    priv_lvl;
  logic                  tsr;
  logic                  exp_valid;
  logic [7:0]            exp_mask;
  logic [`CSR_XLEN-1:0]  exp_rdata;
  logic [`CSR_XLEN-1:0]  exp_raddr;
  logic [`CSR_XLEN-1:0]  exp_taddr;
  logic                  exp_trap;
  logic [1:0]            exp_rft;
  logic [1:0]            exp_priv;
  int                    check_count;
  int                    error_count;
  integer                fd;
  integer                n;
  integer                line_count;
  integer                vec_count;
  integer                other_errors;
  integer                wait_cnt;
  logic [8*256-1:0]      line_buf;
  logic [63:0]           field [14];   // One parsed vector line

  riscv_csrfile i_dut
  (
    .i_riscv_csr_clk         (clk),
    .i_riscv_csr_rst         (rst),
    .i_csr_address           (csr_address),
    .i_csr_op                (csr_op),
    .i_csr_wdata             (csr_wdata),
    .i_external_int          (external_int),
    .i_timer_int             (timer_int),
    .i_pc                    (pc),
    .i_fault_addr            (fault_addr),
    .i_inst                  (inst),
    .i_illegal_inst          (illegal_inst),
    .i_ecall                 (ecall),
    .i_inst_addr_misaligned  (inst_mis),
    .i_load_addr_misaligned  (load_mis),
    .i_store_addr_misaligned (store_mis),
    .i_flush                 (flush),
    .i_stall                 (stall),
    .o_rdata                 (rdata),
    .o_return_address        (return_address),
    .o_trap_address          (trap_address),
    .o_go_to_trap            (go_to_trap),
    .o_return_from_trap      (return_from_trap),
    .o_priv_lvl              (priv_lvl),
    .o_tsr                   (tsr)
  );

  csr_checker u_checker
  (
    .i_riscv_csr_clk        (clk),
    .i_riscv_csr_rst        (rst),
    .i_valid                (exp_valid),
    .i_mask                 (exp_mask),
    .i_csr_address          (csr_address),
    .i_rdata                (rdata),
    .i_return_address       (return_address),
    .i_trap_address         (trap_address),
    .i_go_to_trap           (go_to_trap),
    .i_return_from_trap     (return_from_trap),
    .i_priv_lvl             (priv_lvl),
    .i_tsr                  (tsr),
    .i_exp_rdata            (exp_rdata),
    .i_exp_return_address   (exp_raddr),
    .i_exp_trap_address     (exp_taddr),
    .i_exp_go_to_trap       (exp_trap),
    .i_exp_return_from_trap (exp_rft),
    .i_exp_priv_lvl         (exp_priv),
    .o_check_count          (check_count),
    .o_error_count          (error_count)
  );

  always #2 clk = ~clk;   // 4 ns period

  task init_inputs;
    begin
      csr_address  = csr_pkg::CSR_MSCRATCH;
      csr_op       = csr_pkg::CSR_NONE;
      csr_wdata    = '0;
      external_int = 1'b0;
      timer_int    = 1'b0;
      pc           = '0;
      fault_addr   = '0;
      inst         = '0;
      illegal_inst = 1'b0;
      ecall        = 1'b0;
      inst_mis     = 1'b0;
      load_mis     = 1'b0;
      store_mis    = 1'b0;
      flush        = 1'b0;
      stall        = 1'b0;
      exp_valid    = 1'b0;
      exp_mask     = '0;
      exp_rdata    = '0;
      exp_raddr    = '0;
      exp_taddr    = '0;
      exp_trap     = 1'b0;
      exp_rft      = '0;
      exp_priv     = '0;
    end
  endtask

  task apply_vector;
    begin
      csr_op       <= csr_pkg::csr_op_t'(field[0][2:0]);
      csr_address  <= csr_pkg::csr_addr_t'(field[1][11:0]);
      csr_wdata    <= field[2];
      illegal_inst <= field[3][0];
      ecall        <= field[3][1];
      inst_mis     <= field[3][2];
      load_mis     <= field[3][3];
      store_mis    <= field[3][4];
      flush        <= field[3][5];
      stall        <= field[3][6];
      timer_int    <= field[3][7];
      external_int <= field[3][8];
      pc           <= field[4];
      fault_addr   <= field[5];
      inst         <= field[6][31:0];
      exp_mask     <= field[7][7:0];   // Selects the outputs compared this cycle
      exp_rdata    <= field[8];
      exp_trap     <= field[9][0];
      exp_taddr    <= field[10];
      exp_raddr    <= field[11];
      exp_rft      <= field[12][1:0];
      exp_priv     <= field[13][1:0];
      exp_valid    <= 1'b1;
    end
  endtask

  task run_vectors;
    begin
      while (!$feof(fd) && line_count < MAX_LINES)
      begin
        line_buf   = '0;
        n          = $fgets(line_buf, fd);
        line_count = line_count + 1;
        if (n > 0)
        begin
          // Comment and blank lines yield no fields
          n = $sscanf(line_buf, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                      field[0], field[1], field[2], field[3], field[4], field[5], field[6],
                      field[7], field[8], field[9], field[10], field[11], field[12], field[13]);
          if (n == 14)
          begin
            @(posedge clk);
            apply_vector();
            vec_count = vec_count + 1;
          end
          else if (n > 0)
          begin
            $display("Vector line %0d holds %0d fields where 14 are needed", line_count, n);
            other_errors = other_errors + 1;
          end
        end
      end
      if (!$feof(fd))
      begin
        $display("Vector file still not at its end after %0d lines", MAX_LINES);
        other_errors = other_errors + 1;
      end
      $fclose(fd);
    end
  endtask

  initial
  begin
    clk          = 1'b0;
    rst          = 1'b1;
    other_errors = 0;
    vec_count    = 0;
    line_count   = 0;
    wait_cnt     = 0;
    init_inputs();
    fd = $fopen("test/csr_vectors_input.txt", "r");
    if (fd == 0)
    begin
      $display("The vector file test/csr_vectors_input.txt could not be opened");
      other_errors = other_errors + 1;
    end
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    while (rst === 1'b1 && wait_cnt < RESET_TIMEOUT)
    begin
      @(negedge clk);
      wait_cnt = wait_cnt + 1;
    end
    if (rst === 1'b1)
    begin
      $display("Reset was still active after %0d cycles", RESET_TIMEOUT);
      other_errors = other_errors + 1;
    end
    else if (fd != 0)
      run_vectors();
    @(posedge clk);   // Last vector checked at the preceding falling edge
    exp_valid <= 1'b0;
    if (vec_count == 0)
    begin
      $display("No test vectors were applied to the DUT");
      other_errors = other_errors + 1;
    end
    $display("Vectors: %0d  checks: %0d  errors: %0d", vec_count, check_count,
             error_count + other_errors);
    if (error_count + other_errors == 0)
      $display("Regression passed");
    else
      $display("Regression failed");
    $finish;
  end

endmodule

`default_nettype wire
